// File: logic/cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     isHalt,
    input  logic     isSetLoop,
    input  logic     isLoopJump,
    input  logic     regWrite,
    input  addrT     imm,
    output cpuStateT state,
    output addrT     instrAddr,
    output logic     rfWrite,
    output logic     done
);

    addrT pc;
    addrT nextPc;
    addrT loopCount;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE: state <= ST_IF;
                ST_IF:   state <= ST_ID;
                ST_ID:   state <= isHalt ? ST_HALT : ST_EX;
                ST_EX:   state <= ST_MEM;
                ST_MEM:  state <= ST_WB;
                ST_WB:   state <= ST_IF;
                ST_HALT: state <= ST_HALT; // only rst leaves
                default: state <= ST_IDLE;
            endcase
        end
    end

    // branch decision in EX, pc moves at the end of WB
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= '0;
            nextPc    <= '0;
            loopCount <= '0;
        end
        else if (state == ST_EX)
        begin
            if (isLoopJump && loopCount != '0)
            begin
                nextPc    <= imm;
                loopCount <= loopCount - 1'b1;
            end
            else
            begin
                nextPc <= pc + 1'b1;
            end
            if (isSetLoop)
                loopCount <= imm;
        end
        else if (state == ST_WB)
        begin
            pc <= nextPc;
        end
    end

    assign instrAddr = pc;
    assign rfWrite   = (state == ST_WB) && regWrite;
    assign done      = (state == ST_HALT);

endmodule

// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_W      16
`define ADDR_W      10
`define INSTR_W     18
`define REG_COUNT   4

// instruction fields
`define OP_HI       17
`define OP_LO       14
`define LANE_HI     13
`define LANE_LO     12
`define DEST_HI     11
`define DEST_LO     10
`define SRCA_HI     3
`define SRCA_LO     2
`define SRCB_HI     1
`define SRCB_LO     0
`define IMM_HI      9
`define IMM_LO      0

`endif

// File: logic/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // class 14 is left unnamed and runs as a no-op
    typedef enum logic [3:0] {
        OP_ADD      = 4'd0,
        OP_ADDI     = 4'd1,
        OP_SUB      = 4'd2,
        OP_SUBI     = 4'd3,
        OP_MUL      = 4'd4,
        OP_MULI     = 4'd5,
        OP_AND      = 4'd6,
        OP_OR       = 4'd7,
        OP_NOT      = 4'd8,
        OP_SET      = 4'd9,
        OP_LOAD     = 4'd10,
        OP_STORE    = 4'd11,
        OP_SETLOOP  = 4'd12,
        OP_LOOPJUMP = 4'd13,
        OP_HALT     = 4'd15
    } opClassT;

    // code 3 falls back to one 16-bit lane
    typedef enum logic [1:0] {
        LANE16 = 2'd0,
        LANE8  = 2'd1,
        LANE4  = 2'd2
    } laneT;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_IF,
        ST_ID,
        ST_EX,
        ST_MEM,
        ST_WB,
        ST_HALT
    } cpuStateT;

    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

endpackage

// File: logic/instrDecoder.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instrDecoder import cpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  cpuStateT            state,
    input  logic [`INSTR_W-1:0] instruction,
    output opClassT             opClass,
    output laneT                lane,
    output regIdxT              destIdx,
    output regIdxT              readIdxA,
    output regIdxT              readIdxB,
    output addrT                imm,
    output logic                isImmForm,
    output logic                isLoad,
    output logic                isStore,
    output logic                isHalt,
    output logic                isSetLoop,
    output logic                isLoopJump,
    output logic                regWrite
);

    opClassT opLive;
    regIdxT  destLive;
    logic    readsDest;

    assign opLive   = opClassT'(instruction[`OP_HI:`OP_LO]);
    assign destLive = instruction[`DEST_HI:`DEST_LO];
    // immediate forms, set and store operate on the destination itself
    assign readsDest = opLive inside {OP_ADDI, OP_SUBI, OP_MULI, OP_SET, OP_STORE};

    // live decode so the sequencer can stop at the end of ID
    assign isHalt = (opLive == OP_HALT);

    always_ff @(posedge clk)
    begin
        if (rst || state == ST_IF)
        begin
            opClass    <= OP_ADD;
            lane       <= LANE16;
            destIdx    <= '0;
            readIdxA   <= '0;
            readIdxB   <= '0;
            imm        <= '0;
            isImmForm  <= 1'b0;
            isLoad     <= 1'b0;
            isStore    <= 1'b0;
            isSetLoop  <= 1'b0;
            isLoopJump <= 1'b0;
            regWrite   <= 1'b0;
        end
        else if (state == ST_ID)
        begin
            opClass    <= opLive;
            lane       <= laneT'(instruction[`LANE_HI:`LANE_LO]);
            destIdx    <= destLive;
            readIdxA   <= readsDest ? destLive : instruction[`SRCA_HI:`SRCA_LO];
            readIdxB   <= instruction[`SRCB_HI:`SRCB_LO];
            imm        <= instruction[`IMM_HI:`IMM_LO];
            isImmForm  <= opLive inside {OP_ADDI, OP_SUBI, OP_MULI};
            isLoad     <= (opLive == OP_LOAD);
            isStore    <= (opLive == OP_STORE);
            isSetLoop  <= (opLive == OP_SETLOOP);
            isLoopJump <= (opLive == OP_LOOPJUMP);
            regWrite   <= (opLive <= OP_LOAD); // classes 0..10 write back
        end
    end

endmodule

// File: logic/memStage.sv
`timescale 1ns/1ps

module memStage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpuStateT state,
    input  logic     isLoad,
    input  logic     isStore,
    input  addrT     imm,
    input  wordT     storeData,
    input  wordT     aluResult,
    input  wordT     dataIn,
    output addrT     dataAddr,
    output wordT     dataOut,
    output logic     dataRead,
    output logic     dataWrite,
    output wordT     wbData
);

    wordT loadWord;

    // strobes rise at the end of EX and drop at the end of MEM
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dataRead  <= 1'b0;
            dataWrite <= 1'b0;
        end
        else
        begin
            dataRead  <= (state == ST_EX) && isLoad;
            dataWrite <= (state == ST_EX) && isStore;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_EX)
        begin
            dataAddr <= imm;
            dataOut  <= storeData;
        end
        if (state == ST_MEM)
            loadWord <= dataIn;
    end

    assign wbData = isLoad ? loadWord : aluResult;

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regIdxT readIdxA,
    input  regIdxT readIdxB,
    input  regIdxT writeIdx,
    input  logic   writeEn,
    input  wordT   writeData,
    output wordT   readDataA,
    output wordT   readDataB
);

    wordT regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (writeEn)
        begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

endmodule

// File: logic/simdAlu.sv
`timescale 1ns/1ps

module simdAlu import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpuStateT state,
    input  opClassT  opClass,
    input  laneT     lane,
    input  logic     isImmForm,
    input  addrT     imm,
    input  wordT     operandA,
    input  wordT     operandB,
    output wordT     result
);

    wordT immRep;
    wordT operandSel;
    wordT aluOut;

    // add, sub or mul on lanes of width w, nothing crosses a lane boundary
    function automatic wordT laneArith(wordT a, wordT b, int unsigned w, opClassT op);
        wordT mask;
        wordT x;
        wordT y;
        wordT r;
        wordT acc;
        mask = (w >= 16) ? '1 : wordT'((32'd1 << w) - 1);
        acc  = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (i * w < 16)
            begin
                x = (a >> (i * w)) & mask;
                y = (b >> (i * w)) & mask;
                case (op)
                    OP_SUB, OP_SUBI: r = x - y;
                    OP_MUL, OP_MULI: r = x * y;
                    default:         r = x + y;
                endcase
                acc = acc | ((r & mask) << (i * w));
            end
        end
        return acc;
    endfunction

    always_comb
    begin
        case (lane)
            LANE8:   immRep = {2{imm[7:0]}};
            LANE4:   immRep = {4{imm[3:0]}};
            default: immRep = wordT'(imm); // zero-extended
        endcase
    end

    assign operandSel = isImmForm ? immRep : operandB;

    always_comb
    begin
        case (opClass)
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_MULI:
            begin
                case (lane)
                    LANE8:   aluOut = laneArith(operandA, operandSel, 8, opClass);
                    LANE4:   aluOut = laneArith(operandA, operandSel, 4, opClass);
                    default: aluOut = laneArith(operandA, operandSel, 16, opClass);
                endcase
            end
            OP_AND:  aluOut = operandA & operandB;
            OP_OR:   aluOut = operandA | operandB;
            OP_NOT:  aluOut = ~operandA;
            OP_SET:  aluOut = immRep;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result <= '0;
        else if (state == ST_EX)
            result <= aluOut;
    end

endmodule

// File: logic/simdCpuTop.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module simdCpuTop import cpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [`INSTR_W-1:0] instruction,
    output addrT                instrAddr,
    input  wordT                dataIn,
    output wordT                dataOut,
    output addrT                dataAddr,
    output logic                dataRead,
    output logic                dataWrite,
    output logic                done
);

    cpuStateT state;
    opClassT  opClass;
    laneT     lane;
    regIdxT   destIdx;
    regIdxT   readIdxA;
    regIdxT   readIdxB;
    addrT     imm;
    logic     isImmForm;
    logic     isLoad;
    logic     isStore;
    logic     isHalt;
    logic     isSetLoop;
    logic     isLoopJump;
    logic     regWrite;
    logic     rfWrite;
    wordT     readDataA;
    wordT     readDataB;
    wordT     aluResult;
    wordT     wbData;

    cpuSequencer i_sequencer (
        .clk        (clk),
        .rst        (rst),
        .isHalt     (isHalt),
        .isSetLoop  (isSetLoop),
        .isLoopJump (isLoopJump),
        .regWrite   (regWrite),
        .imm        (imm),
        .state      (state),
        .instrAddr  (instrAddr),
        .rfWrite    (rfWrite),
        .done       (done)
    );

    instrDecoder i_decoder (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .instruction (instruction),
        .opClass     (opClass),
        .lane        (lane),
        .destIdx     (destIdx),
        .readIdxA    (readIdxA),
        .readIdxB    (readIdxB),
        .imm         (imm),
        .isImmForm   (isImmForm),
        .isLoad      (isLoad),
        .isStore     (isStore),
        .isHalt      (isHalt),
        .isSetLoop   (isSetLoop),
        .isLoopJump  (isLoopJump),
        .regWrite    (regWrite)
    );

    regFile i_regFile (
        .clk       (clk),
        .rst       (rst),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .writeIdx  (destIdx),
        .writeEn   (rfWrite),
        .writeData (wbData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    simdAlu i_alu (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .opClass   (opClass),
        .lane      (lane),
        .isImmForm (isImmForm),
        .imm       (imm),
        .operandA  (readDataA),
        .operandB  (readDataB),
        .result    (aluResult)
    );

    memStage i_memStage (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .isLoad    (isLoad),
        .isStore   (isStore),
        .imm       (imm),
        .storeData (readDataA), // port A holds the destination for store
        .aluResult (aluResult),
        .dataIn    (dataIn),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .wbData    (wbData)
    );

endmodule

// File: tb.f
+incdir+logic
logic/cpu_pkg.sv
logic/regFile.sv
logic/cpuSequencer.sv
logic/instrDecoder.sv
logic/simdAlu.sv
logic/memStage.sv
logic/simdCpuTop.sv
tb/cpu_assert.sv
tb/tbSimdCpu.sv

// File: tb/cpu_assert.sv
`timescale 1ns/1ps

module cpuAssert import cpu_pkg::*; (
    input logic     clk,
    input logic     rst,
    input cpuStateT state,
    input logic     dataRead,
    input logic     dataWrite,
    input logic     done
);

    int assertFails = 0;

    assert property (@(posedge clk) disable iff (rst) !(dataRead && dataWrite))
        else begin assertFails++; $error("dataRead and dataWrite high together"); end

    // single-cycle strobes
    assert property (@(posedge clk) disable iff (rst) dataRead |=> !dataRead)
        else begin assertFails++; $error("dataRead held past one cycle"); end
    assert property (@(posedge clk) disable iff (rst) dataWrite |=> !dataWrite)
        else begin assertFails++; $error("dataWrite held past one cycle"); end

    assert property (@(posedge clk) disable iff (rst) (dataRead || dataWrite) |-> state == ST_MEM)
        else begin assertFails++; $error("data strobe outside the MEM state"); end

    assert property (@(posedge clk) disable iff (rst) done |=> done)
        else begin assertFails++; $error("done dropped without reset"); end

endmodule

bind simdCpuTop cpuAssert i_assert (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .dataRead  (dataRead),
    .dataWrite (dataWrite),
    .done      (done)
);

// File: tb/tbSimdCpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbSimdCpu import cpu_pkg::*; ();

    localparam int MEM_DEPTH = 1 << `ADDR_W;
    localparam int REF_STEP_LIMIT = 4000;

    logic                clk;
    logic                rst;
    logic [`INSTR_W-1:0] instruction;
    addrT                instrAddr;
    wordT                dataIn;
    wordT                dataOut;
    addrT                dataAddr;
    logic                dataRead;
    logic                dataWrite;
    logic                done;

    logic [`INSTR_W-1:0] progMem [MEM_DEPTH];
    wordT                dataMem [MEM_DEPTH];
    wordT                initMem [MEM_DEPTH];
    wordT                expMem [MEM_DEPTH];
    logic                storedAt [MEM_DEPTH];

    integer seed;
    int     pcw;
    int     cycles;
    int     cycleLimit;
    int     passCount;
    int     failCount;
    int     testErrs;
    string  testName;
    logic   checkReq;
    logic   checkDone;

    simdCpuTop i_dut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .instrAddr   (instrAddr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .dataAddr    (dataAddr),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .done        (done)
    );

    // both memories read combinationally
    assign instruction = progMem[instrAddr];
    // data word only while the read strobe is up, inverted otherwise
    assign dataIn      = dataRead ? dataMem[dataAddr] : ~dataMem[dataAddr];

    always @(posedge clk)
    begin
        if (dataWrite)
            dataMem[dataAddr] <= dataOut;
    end

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit)
        begin
            $display("timeout: run went past the limit of %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic wordT replicate(logic [1:0] laneSel, logic [9:0] immVal);
        case (laneSel)
            2'd1:    return {immVal[7:0], immVal[7:0]};
            2'd2:    return {immVal[3:0], immVal[3:0], immVal[3:0], immVal[3:0]};
            default: return {6'b0, immVal}; // lane code 3 behaves as 16
        endcase
    endfunction

    function automatic wordT scalarOp(logic [3:0] op, wordT x, wordT y);
        case (op)
            OP_ADD, OP_ADDI: return x + y;
            OP_SUB, OP_SUBI: return x - y;
            default:         return x * y;
        endcase
    endfunction

    // each lane computed on its own and cut to its width
    function automatic wordT laneOp(logic [3:0] op, logic [1:0] laneSel, wordT a, wordT b);
        wordT res;
        wordT part;
        res = '0;
        case (laneSel)
            2'd1:
                for (int k = 0; k < 2; k++)
                begin
                    part = scalarOp(op, {8'h0, a[k*8 +: 8]}, {8'h0, b[k*8 +: 8]});
                    res[k*8 +: 8] = part[7:0];
                end
            2'd2:
                for (int k = 0; k < 4; k++)
                begin
                    part = scalarOp(op, {12'h0, a[k*4 +: 4]}, {12'h0, b[k*4 +: 4]});
                    res[k*4 +: 4] = part[3:0];
                end
            default: res = scalarOp(op, a, b);
        endcase
        return res;
    endfunction

    // interprets progMem on a copy of initMem and returns the instruction count
    function automatic int refRun();
        wordT                regs [4];
        int                  pc;
        int                  loopCnt;
        int                  steps;
        logic [`INSTR_W-1:0] ins;
        logic [3:0]          op;
        logic [1:0]          ln;
        logic [1:0]          rd;
        logic [9:0]          iv;
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            expMem[i]   = initMem[i];
            storedAt[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++)
            regs[i] = '0;
        pc      = 0;
        loopCnt = 0;
        steps   = 0;
        while (steps < REF_STEP_LIMIT)
        begin
            ins = progMem[pc];
            op  = ins[17:14];
            ln  = ins[13:12];
            rd  = ins[11:10];
            iv  = ins[9:0];
            steps++;
            if (op == OP_HALT)
                break;
            pc = (pc + 1) % MEM_DEPTH;
            case (op)
                OP_ADD, OP_SUB, OP_MUL:
                    regs[rd] = laneOp(op, ln, regs[ins[3:2]], regs[ins[1:0]]);
                OP_ADDI, OP_SUBI, OP_MULI:
                    regs[rd] = laneOp(op, ln, regs[rd], replicate(ln, iv));
                OP_AND:  regs[rd] = regs[ins[3:2]] & regs[ins[1:0]];
                OP_OR:   regs[rd] = regs[ins[3:2]] | regs[ins[1:0]];
                OP_NOT:  regs[rd] = ~regs[ins[3:2]];
                OP_SET:  regs[rd] = replicate(ln, iv);
                OP_LOAD: regs[rd] = expMem[iv];
                OP_STORE:
                begin
                    expMem[iv]   = regs[rd];
                    storedAt[iv] = 1'b1;
                end
                OP_SETLOOP: loopCnt = iv;
                OP_LOOPJUMP:
                    if (loopCnt != 0)
                    begin
                        pc = iv;
                        loopCnt--;
                    end
                default: ; // class 14
            endcase
        end
        return steps;
    endfunction

    function automatic logic [`INSTR_W-1:0] encode(logic [3:0] op, logic [1:0] laneSel,
                                                   logic [1:0] rd, logic [9:0] field);
        return {op, laneSel, rd, field};
    endfunction

    function automatic logic [`INSTR_W-1:0] regForm(logic [3:0] op, logic [1:0] laneSel,
                                                    logic [1:0] rd, logic [1:0] ra, logic [1:0] rb);
        return encode(op, laneSel, rd, {6'b0, ra, rb});
    endfunction

    task automatic put(input logic [`INSTR_W-1:0] ins);
        progMem[pcw] = ins;
        pcw++;
    endtask

    task automatic newProgram();
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            progMem[i] = encode(OP_HALT, 2'd0, 2'd0, 10'd0);
            initMem[i] = wordT'(i * 16'h2f1d) ^ 16'h0f0f; // odd multiplier keeps words unique
        end
        pcw = 0;
    endtask

    task automatic buildRegArith();
        logic [3:0] ops [3];
        int         slot;
        ops = '{OP_ADD, OP_SUB, OP_MUL};
        newProgram();
        initMem[100] = 16'hF9C7; // carries and overflow in every lane
        initMem[101] = 16'h8A5B;
        put(encode(OP_LOAD, 2'd0, 2'd0, 10'd100));
        put(encode(OP_LOAD, 2'd0, 2'd1, 10'd101));
        slot = 200;
        for (int ln = 0; ln < 3; ln++)
            for (int k = 0; k < 3; k++)
            begin
                put(regForm(ops[k], 2'(ln), 2'd2, 2'd0, 2'd1));
                put(encode(OP_STORE, 2'd0, 2'd2, 10'(slot)));
                slot++;
            end
    endtask

    task automatic buildImmArith();
        logic [3:0] ops [3];
        int         slot;
        ops = '{OP_ADDI, OP_SUBI, OP_MULI};
        newProgram();
        initMem[110] = 16'hE7D6;
        slot = 220;
        for (int ln = 0; ln < 4; ln++)
        begin
            put(encode(OP_SET, 2'(ln), 2'd0, 10'h2B7));
            put(encode(OP_STORE, 2'd0, 2'd0, 10'(slot)));
            slot++;
            for (int k = 0; k < 3; k++)
            begin
                put(encode(OP_LOAD, 2'd0, 2'd1, 10'd110));
                put(encode(ops[k], 2'(ln), 2'd1, 10'h3D9));
                put(encode(OP_STORE, 2'd0, 2'd1, 10'(slot)));
                slot++;
            end
        end
    endtask

    task automatic buildLogic();
        newProgram();
        put(encode(OP_SET, 2'd1, 2'd0, 10'h0C3)); // C3C3
        put(encode(OP_SET, 2'd2, 2'd1, 10'h006)); // 6666
        put(encode(OP_SET, 2'd0, 2'd3, 10'h35A));
        put(regForm(OP_AND, 2'd0, 2'd2, 2'd0, 2'd1));
        put(encode(OP_STORE, 2'd0, 2'd2, 10'd240));
        put(regForm(OP_OR, 2'd0, 2'd2, 2'd0, 2'd3));
        put(encode(OP_STORE, 2'd0, 2'd2, 10'd241));
        put(regForm(OP_NOT, 2'd0, 2'd2, 2'd1, 2'd0));
        put(encode(OP_STORE, 2'd0, 2'd2, 10'd242));
        put(regForm(OP_AND, 2'd0, 2'd2, 2'd2, 2'd0));
        put(encode(OP_STORE, 2'd0, 2'd2, 10'd243));
        put(encode(OP_STORE, 2'd0, 2'd0, 10'd244));
        put(encode(OP_STORE, 2'd0, 2'd1, 10'd245));
    endtask

    task automatic buildCopy();
        newProgram();
        initMem[300] = 16'hA55A;
        initMem[301] = 16'h0001;
        initMem[302] = 16'hFFFF;
        initMem[303] = 16'h8000;
        for (int i = 0; i < 4; i++)
            put(encode(OP_LOAD, 2'd0, 2'(i), 10'(300 + i)));
        for (int i = 0; i < 4; i++)
            put(encode(OP_STORE, 2'd0, 2'(i), 10'(400 + i)));
        put(encode(OP_LOAD, 2'd0, 2'd0, 10'd303)); // back to back load and store
        put(encode(OP_STORE, 2'd0, 2'd0, 10'd404));
    endtask

    task automatic buildLoop();
        int top;
        newProgram();
        put(encode(OP_SET, 2'd0, 2'd0, 10'd0));
        put(encode(OP_SETLOOP, 2'd0, 2'd0, 10'd3));
        top = pcw;
        put(encode(OP_ADDI, 2'd0, 2'd0, 10'd1));
        put(encode(OP_LOOPJUMP, 2'd0, 2'd0, 10'(top)));
        put(encode(OP_STORE, 2'd0, 2'd0, 10'd500));
    endtask

    task automatic buildRandom();
        logic [3:0]  op;
        logic [31:0] r;
        newProgram();
        for (int i = 0; i < 4; i++)
        begin
            initMem[600 + i] = wordT'($random(seed));
            put(encode(OP_LOAD, 2'd0, 2'(i), 10'(600 + i)));
        end
        for (int i = 0; i < 24; i++)
        begin
            r  = $random(seed);
            op = 4'(r[7:0] % 10); // arithmetic, logic and set
            put(encode(op, r[9:8], r[11:10], r[21:12]));
        end
        for (int i = 0; i < 4; i++)
            put(encode(OP_STORE, 2'd0, 2'(i), 10'(700 + i)));
    endtask

    task automatic runTest(input string name);
        int steps;
        int waited;
        int testLimit;
        testName   = name;
        steps      = refRun();
        testLimit  = 5 * steps + 5;
        cycleLimit = cycleLimit + testLimit + 12; // reset and post-halt cycles
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < MEM_DEPTH; i++)
            dataMem[i] = initMem[i];
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        testErrs = 0;
        waited   = 0;
        while (!done && waited < testLimit)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            $display("%s: processor did not halt within %0d cycles", name, testLimit);
            testErrs++;
        end
        else
        begin
            repeat (4) @(negedge clk);
            if (!done)
            begin
                $display("%s: done fell before reset", name);
                testErrs++;
            end
            checkReq = 1'b1;
            wait (checkDone);
            checkReq  = 1'b0;
            checkDone = 1'b0;
        end
        if (testErrs == 0)
        begin
            $display("test %s passed after %0d instructions", name, steps);
            passCount++;
        end
        else
        begin
            $display("test %s failed with %0d errors", name, testErrs);
            failCount++;
        end
    endtask

    // compares every word the reference stored
    always @(posedge checkReq)
    begin
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            if (storedAt[a] && dataMem[a] !== expMem[a])
            begin
                $display("MISMATCH %s addr %0d expected %h actual %h",
                         testName, a, expMem[a], dataMem[a]);
                testErrs++;
            end
        end
        checkDone = 1'b1;
    end

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        checkReq   = 1'b0;
        checkDone  = 1'b0;
        cycles     = 0;
        cycleLimit = 100;
        passCount  = 0;
        failCount  = 0;
        seed       = 32'he9c8600c;
        buildRegArith();
        runTest("reg_arith");
        buildImmArith();
        runTest("imm_arith_set");
        buildLogic();
        runTest("logic_ops");
        buildCopy();
        runTest("load_store_copy");
        buildLoop();
        runTest("hw_loop");
        buildRandom();
        runTest("random_mix");
        if (i_dut.i_assert.assertFails != 0)
        begin
            $display("%0d assertion failures on the data port or done",
                     i_dut.i_assert.assertFails);
            failCount++;
        end
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
